/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_top
FILELIST = tb.f
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the simulation, check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* branch_unit.sv */
`timescale 1ns/1ps
`include "id_defs.svh"

module branch_unit import id_pkg::*; (
	input  word_t pc_i,
	input  word_t instr_i,
	input  word_t rs_val_i,
	input  word_t rt_val_i,
	output logic  taken_o,
	output word_t target_o,
	output word_t return_addr_o
);

	word_t pc_plus4;
	word_t br_target;
	word_t j_target;
	logic  br_hit;
	logic  j_hit;
	logic  jr_hit;
	logic  link;

	assign pc_plus4  = pc_i + `WORD_W'(`ID_INSTR_PC_STEP);
	assign br_target = pc_plus4 + {{14{instr_i[15]}}, instr_i[15:0], 2'b00};
	assign j_target  = {pc_plus4[31:28], instr_i[25:0], 2'b00};

	always_comb begin
		br_hit = 1'b0;
		j_hit  = 1'b0;
		jr_hit = 1'b0;
		link   = 1'b0;
		case (instr_i[31:26])
			`ID_OP_SPECIAL: begin
				jr_hit = (instr_i[5:0] == `ID_JR) || (instr_i[5:0] == `ID_JALR);
				link   = (instr_i[5:0] == `ID_JALR);
			end
			`ID_OP_REGIMM: begin
				case (instr_i[20:16])
					`ID_BGEZ: br_hit = !rs_val_i[31];
					`ID_BLTZ: br_hit = rs_val_i[31];
					`ID_BGEZAL: begin
						br_hit = !rs_val_i[31];
						link   = 1'b1; // links taken or not.
					end
					`ID_BLTZAL: begin
						br_hit = rs_val_i[31];
						link   = 1'b1;
					end
					default: ;
				endcase
			end
			`ID_BEQ:  br_hit = (rs_val_i == rt_val_i);
			`ID_BNE:  br_hit = (rs_val_i != rt_val_i);
			`ID_BGTZ: br_hit = !rs_val_i[31] && (rs_val_i != '0);
			`ID_BLEZ: br_hit = rs_val_i[31] || (rs_val_i == '0);
			`ID_J:    j_hit = 1'b1;
			`ID_JAL: begin
				j_hit = 1'b1;
				link  = 1'b1;
			end
			default: ;
		endcase
	end

	assign taken_o  = br_hit | j_hit | jr_hit;
	assign target_o = br_hit ? br_target :
		j_hit ? j_target :
		jr_hit ? rs_val_i : '0; // zero when not taken.

	// skips the delay slot.
	assign return_addr_o = link ? pc_plus4 + `WORD_W'(`ID_INSTR_PC_STEP) : '0;

endmodule

/* id_dec_if.sv */
`timescale 1ns/1ps

interface dec_if import id_pkg::*; ();

	aluop_t   aluop;
	logic     wr_en;
	reg_idx_t wr_addr;
	logic     mem_to_reg; // loads.
	logic     ram_we;     // stores.
	logic     rs_ren;
	logic     rt_ren;
	logic     link;       // write value is the return address.
	logic     instr_valid;

	modport dec (
		output aluop, wr_en, wr_addr, mem_to_reg, ram_we,
		output rs_ren, rt_ren, link, instr_valid
	);

	modport sink (
		input aluop, wr_en, wr_addr, mem_to_reg, ram_we,
		input rs_ren, rt_ren, link, instr_valid
	);

endinterface

/* id_defs.svh */
`ifndef ID_DEFS_SVH
`define ID_DEFS_SVH

`define WORD_W           32
`define ID_INSTR_PC_STEP 4

// ============================================================
// opcode groups
// ============================================================
`define ID_OP_SPECIAL 6'b000000
`define ID_OP_REGIMM  6'b000001

// special group, by funct.
`define ID_AND  6'b100100
`define ID_OR   6'b100101
`define ID_XOR  6'b100110
`define ID_NOR  6'b100111
`define ID_ADD  6'b100000
`define ID_ADDU 6'b100001
`define ID_SUB  6'b100010
`define ID_SUBU 6'b100011
`define ID_SLT  6'b101010
`define ID_SLTU 6'b101011
`define ID_SLLV 6'b000100
`define ID_SRLV 6'b000110
`define ID_SRAV 6'b000111
`define ID_SLL  6'b000000
`define ID_SRL  6'b000010
`define ID_SRA  6'b000011
`define ID_JR   6'b001000
`define ID_JALR 6'b001001

// regimm group, by rt.
`define ID_BLTZ   5'b00000
`define ID_BGEZ   5'b00001
`define ID_BLTZAL 5'b10000
`define ID_BGEZAL 5'b10001

// main opcodes.
`define ID_ANDI  6'b001100
`define ID_ORI   6'b001101
`define ID_XORI  6'b001110
`define ID_LUI   6'b001111
`define ID_ADDI  6'b001000
`define ID_ADDIU 6'b001001
`define ID_SLTI  6'b001010
`define ID_SLTIU 6'b001011
`define ID_LB    6'b100000
`define ID_LH    6'b100001
`define ID_LW    6'b100011
`define ID_LBU   6'b100100
`define ID_LHU   6'b100101
`define ID_SB    6'b101000
`define ID_SH    6'b101001
`define ID_SW    6'b101011
`define ID_BEQ   6'b000100
`define ID_BNE   6'b000101
`define ID_BLEZ  6'b000110
`define ID_BGTZ  6'b000111
`define ID_J     6'b000010
`define ID_JAL   6'b000011

// ============================================================
// alu operation codes
// ============================================================
`define ALUOP_NOP    8'h00
`define ALUOP_AND    8'h01
`define ALUOP_OR     8'h02
`define ALUOP_XOR    8'h03
`define ALUOP_NOR    8'h04
`define ALUOP_ADD    8'h05
`define ALUOP_ADDU   8'h06
`define ALUOP_SUB    8'h07
`define ALUOP_SUBU   8'h08
`define ALUOP_SLT    8'h09
`define ALUOP_SLTU   8'h0a
`define ALUOP_SLLV   8'h0b
`define ALUOP_SRLV   8'h0c
`define ALUOP_SRAV   8'h0d
`define ALUOP_SLL    8'h0e
`define ALUOP_SRL    8'h0f
`define ALUOP_SRA    8'h10
`define ALUOP_ANDI   8'h11
`define ALUOP_ORI    8'h12
`define ALUOP_XORI   8'h13
`define ALUOP_LUI    8'h14
`define ALUOP_ADDI   8'h15
`define ALUOP_ADDIU  8'h16
`define ALUOP_SLTI   8'h17
`define ALUOP_SLTIU  8'h18
`define ALUOP_LB     8'h20
`define ALUOP_LBU    8'h21
`define ALUOP_LH     8'h22
`define ALUOP_LHU    8'h23
`define ALUOP_LW     8'h24
`define ALUOP_SB     8'h28
`define ALUOP_SH     8'h29
`define ALUOP_SW     8'h2a
`define ALUOP_BEQ    8'h30
`define ALUOP_BNE    8'h31
`define ALUOP_BGTZ   8'h32
`define ALUOP_BLEZ   8'h33
`define ALUOP_BGEZ   8'h34
`define ALUOP_BLTZ   8'h35
`define ALUOP_BGEZAL 8'h36
`define ALUOP_BLTZAL 8'h37
`define ALUOP_J      8'h38
`define ALUOP_JAL    8'h39
`define ALUOP_JR     8'h3a
`define ALUOP_JALR   8'h3b

`endif

/* id_ex_reg.sv */
`timescale 1ns/1ps

module id_ex_reg import id_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  logic     in_valid_i,
	input  logic     hazard_i,
	input  logic     out_ready_i,
	output logic     in_ready_o,
	output logic     out_valid_o,
	dec_if.sink      ctl,
	input  word_t    pc_i,
	input  word_t    instr_i,
	input  word_t    rs_val_i,
	input  word_t    rt_val_i,
	input  logic     taken_i,
	input  word_t    target_i,
	input  word_t    return_addr_i,
	output word_t    pc_o,
	output word_t    instr_o,
	output aluop_t   aluop_o,
	output word_t    rs_data_o,
	output word_t    rt_data_o,
	output imm16_t   imm16_o,
	output logic     wr_en_o,
	output reg_idx_t wr_addr_o,
	output logic     mem_to_reg_o,
	output logic     ram_we_o,
	output word_t    return_addr_o,
	output logic     branch_en_o,
	output word_t    branch_addr_o,
	output logic     instr_valid_o
);

	logic accept;

	// room when empty or draining, and no load-use stall.
	assign in_ready_o = rst && (!out_valid_o || out_ready_i) && !hazard_i;
	assign accept     = in_valid_i && in_ready_o;

	// ============================================================
	// control state
	// ============================================================
	always_ff @(posedge clk) begin
		if (!rst) begin
			out_valid_o <= 1'b0;
			branch_en_o <= 1'b0;
			wr_en_o     <= 1'b0;
			ram_we_o    <= 1'b0;
		end else if (accept) begin
			out_valid_o <= 1'b1;
			branch_en_o <= taken_i;
			wr_en_o     <= ctl.wr_en;
			ram_we_o    <= ctl.ram_we;
		end else if (out_ready_i) begin
			out_valid_o <= 1'b0; // taken, nothing behind it.
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			pc_o          <= pc_i;
			instr_o       <= instr_i;
			aluop_o       <= ctl.aluop;
			rs_data_o     <= rs_val_i;
			rt_data_o     <= rt_val_i;
			wr_addr_o     <= ctl.wr_addr;
			mem_to_reg_o  <= ctl.mem_to_reg;
			return_addr_o <= ctl.link ? return_addr_i : '0;
			branch_addr_o <= target_i;
			instr_valid_o <= ctl.instr_valid;
		end
	end

	assign imm16_o = instr_o[15:0];

endmodule

/* id_pkg.sv */
`include "id_defs.svh"

package id_pkg;

	// data word or program counter.
	typedef logic [`WORD_W-1:0] word_t;

	// register file index.
	typedef logic [4:0] reg_idx_t;

	typedef logic [7:0] aluop_t;

	// raw immediate field.
	typedef logic [15:0] imm16_t;

endpackage

/* id_sva.sv */
`timescale 1ns/1ps

module id_sva import id_pkg::*; (
	input logic  clk,
	input logic  rst,
	input logic  out_valid_o,
	input logic  out_ready_i,
	input logic  hazard_i,
	input word_t pc_o,
	input word_t instr_o,
	input word_t rs_data_o,
	input word_t rt_data_o,
	input word_t branch_addr_o,
	input word_t return_addr_o
);

	int err_cnt = 0;

	a_reset_clears: assert property (@(posedge clk) !rst |=> !out_valid_o)
		else begin
			$error("out_valid_o high after a reset cycle");
			err_cnt++;
		end

	// pending output must hold under back-pressure.
	a_hold_stable: assert property (@(posedge clk) disable iff (!rst)
		(out_valid_o && !out_ready_i) |=> out_valid_o &&
		$stable({pc_o, instr_o, rs_data_o, rt_data_o, branch_addr_o, return_addr_o}))
		else begin
			$error("outputs changed while stalled");
			err_cnt++;
		end

	// nothing is taken in while a load-use stall is up.
	a_hazard_stall: assert property (@(posedge clk) disable iff (!rst)
		hazard_i |=> $stable({pc_o, instr_o, rs_data_o, rt_data_o}) &&
		(!out_valid_o || $past(out_valid_o && !out_ready_i)))
		else begin
			$error("an instruction was taken in during a load-use hazard");
			err_cnt++;
		end

endmodule

bind id_ex_reg id_sva u_sva (.*);

/* id_top.sv */
`timescale 1ns/1ps

module id_top import id_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  logic     in_valid_i,
	input  word_t    pc_i,
	input  word_t    instr_i,
	input  word_t    rs_data_i,
	input  word_t    rt_data_i,
	input  logic     out_ready_i,
	input  logic     ex_wr_en_i,
	input  reg_idx_t ex_wr_addr_i,
	input  word_t    ex_wr_data_i,
	input  logic     mem_wr_en_i,
	input  reg_idx_t mem_wr_addr_i,
	input  word_t    mem_wr_data_i,
	input  logic     exe_mem_to_reg_i,
	input  reg_idx_t exe_wr_addr_i,
	output logic     in_ready_o,
	output logic     out_valid_o,
	output word_t    pc_o,
	output word_t    instr_o,
	output aluop_t   aluop_o,
	output word_t    rs_data_o,
	output word_t    rt_data_o,
	output imm16_t   imm16_o,
	output logic     wr_en_o,
	output reg_idx_t wr_addr_o,
	output logic     mem_to_reg_o,
	output logic     ram_we_o,
	output word_t    return_addr_o,
	output logic     branch_en_o,
	output word_t    branch_addr_o,
	output logic     instr_valid_o
);

	word_t rs_val;
	word_t rt_val;
	logic  hazard;
	logic  taken;
	word_t target;
	word_t return_addr;

	dec_if u_dec_if ();

	instr_decoder u_decoder (
		.instr_i (instr_i),
		.ctl     (u_dec_if.dec)
	);

	// ============================================================
	// operands and branch resolution
	// ============================================================
	operand_bypass u_bypass (
		.ctl              (u_dec_if.sink),
		.instr_i          (instr_i),
		.rs_data_i        (rs_data_i),
		.rt_data_i        (rt_data_i),
		.ex_wr_en_i       (ex_wr_en_i),
		.ex_wr_addr_i     (ex_wr_addr_i),
		.ex_wr_data_i     (ex_wr_data_i),
		.mem_wr_en_i      (mem_wr_en_i),
		.mem_wr_addr_i    (mem_wr_addr_i),
		.mem_wr_data_i    (mem_wr_data_i),
		.exe_mem_to_reg_i (exe_mem_to_reg_i),
		.exe_wr_addr_i    (exe_wr_addr_i),
		.rs_val_o         (rs_val),
		.rt_val_o         (rt_val),
		.hazard_o         (hazard)
	);

	branch_unit u_branch (
		.pc_i          (pc_i),
		.instr_i       (instr_i),
		.rs_val_i      (rs_val), // forwarded values.
		.rt_val_i      (rt_val),
		.taken_o       (taken),
		.target_o      (target),
		.return_addr_o (return_addr)
	);

	id_ex_reg u_id_ex_reg (
		.clk           (clk),
		.rst           (rst),
		.in_valid_i    (in_valid_i),
		.hazard_i      (hazard),
		.out_ready_i   (out_ready_i),
		.in_ready_o    (in_ready_o),
		.out_valid_o   (out_valid_o),
		.ctl           (u_dec_if.sink),
		.pc_i          (pc_i),
		.instr_i       (instr_i),
		.rs_val_i      (rs_val),
		.rt_val_i      (rt_val),
		.taken_i       (taken),
		.target_i      (target),
		.return_addr_i (return_addr),
		.pc_o          (pc_o),
		.instr_o       (instr_o),
		.aluop_o       (aluop_o),
		.rs_data_o     (rs_data_o),
		.rt_data_o     (rt_data_o),
		.imm16_o       (imm16_o),
		.wr_en_o       (wr_en_o),
		.wr_addr_o     (wr_addr_o),
		.mem_to_reg_o  (mem_to_reg_o),
		.ram_we_o      (ram_we_o),
		.return_addr_o (return_addr_o),
		.branch_en_o   (branch_en_o),
		.branch_addr_o (branch_addr_o),
		.instr_valid_o (instr_valid_o)
	);

endmodule

/* instr_decoder.sv */
`timescale 1ns/1ps
`include "id_defs.svh"

module instr_decoder import id_pkg::*; (
	input  word_t instr_i,
	dec_if.dec    ctl
);

	logic [5:0] op;
	logic [5:0] funct;
	reg_idx_t   rs;
	reg_idx_t   rt;
	reg_idx_t   rd;
	aluop_t     aluop;

	assign op    = instr_i[31:26];
	assign rs    = instr_i[25:21];
	assign rt    = instr_i[20:16];
	assign rd    = instr_i[15:11];
	assign funct = instr_i[5:0];

	// ============================================================
	// instruction to alu operation
	// ============================================================
	always_comb begin
		aluop = `ALUOP_NOP;
		case (op)
			`ID_OP_SPECIAL: begin
				case (funct)
					`ID_AND:  aluop = `ALUOP_AND;
					`ID_OR:   aluop = `ALUOP_OR;
					`ID_XOR:  aluop = `ALUOP_XOR;
					`ID_NOR:  aluop = `ALUOP_NOR;
					`ID_ADD:  aluop = `ALUOP_ADD;
					`ID_ADDU: aluop = `ALUOP_ADDU;
					`ID_SUB:  aluop = `ALUOP_SUB;
					`ID_SUBU: aluop = `ALUOP_SUBU;
					`ID_SLT:  aluop = `ALUOP_SLT;
					`ID_SLTU: aluop = `ALUOP_SLTU;
					`ID_SLLV: aluop = `ALUOP_SLLV;
					`ID_SRLV: aluop = `ALUOP_SRLV;
					`ID_SRAV: aluop = `ALUOP_SRAV;
					`ID_SLL:  if (rs == '0) aluop = `ALUOP_SLL; // bits 31..21 all zero.
					`ID_SRL:  if (rs == '0) aluop = `ALUOP_SRL;
					`ID_SRA:  if (rs == '0) aluop = `ALUOP_SRA;
					`ID_JR:   aluop = `ALUOP_JR;
					`ID_JALR: aluop = `ALUOP_JALR;
					default: ;
				endcase
			end
			`ID_OP_REGIMM: begin
				case (rt)
					`ID_BGEZ:   aluop = `ALUOP_BGEZ;
					`ID_BLTZ:   aluop = `ALUOP_BLTZ;
					`ID_BGEZAL: aluop = `ALUOP_BGEZAL;
					`ID_BLTZAL: aluop = `ALUOP_BLTZAL;
					default: ;
				endcase
			end
			`ID_ANDI:  aluop = `ALUOP_ANDI;
			`ID_ORI:   aluop = `ALUOP_ORI;
			`ID_XORI:  aluop = `ALUOP_XORI;
			`ID_LUI:   aluop = `ALUOP_LUI;
			`ID_ADDI:  aluop = `ALUOP_ADDI;
			`ID_ADDIU: aluop = `ALUOP_ADDIU;
			`ID_SLTI:  aluop = `ALUOP_SLTI;
			`ID_SLTIU: aluop = `ALUOP_SLTIU;
			`ID_LB:    aluop = `ALUOP_LB;
			`ID_LBU:   aluop = `ALUOP_LBU;
			`ID_LH:    aluop = `ALUOP_LH;
			`ID_LHU:   aluop = `ALUOP_LHU;
			`ID_LW:    aluop = `ALUOP_LW;
			`ID_SB:    aluop = `ALUOP_SB;
			`ID_SH:    aluop = `ALUOP_SH;
			`ID_SW:    aluop = `ALUOP_SW;
			`ID_BEQ:   aluop = `ALUOP_BEQ;
			`ID_BNE:   aluop = `ALUOP_BNE;
			`ID_BGTZ:  aluop = `ALUOP_BGTZ;
			`ID_BLEZ:  aluop = `ALUOP_BLEZ;
			`ID_J:     aluop = `ALUOP_J;
			`ID_JAL:   aluop = `ALUOP_JAL;
			default: ;
		endcase
	end

	// ============================================================
	// write controls and read enables per group
	// ============================================================
	always_comb begin
		ctl.wr_en      = 1'b0;
		ctl.wr_addr    = rd;
		ctl.mem_to_reg = 1'b0;
		ctl.ram_we     = 1'b0;
		ctl.rs_ren     = 1'b0;
		ctl.rt_ren     = 1'b0;
		ctl.link       = 1'b0;
		case (aluop)
			`ALUOP_AND, `ALUOP_OR, `ALUOP_XOR, `ALUOP_NOR, `ALUOP_ADD, `ALUOP_ADDU,
			`ALUOP_SUB, `ALUOP_SUBU, `ALUOP_SLT, `ALUOP_SLTU,
			`ALUOP_SLLV, `ALUOP_SRLV, `ALUOP_SRAV: begin
				ctl.wr_en  = 1'b1;
				ctl.rs_ren = 1'b1;
				ctl.rt_ren = 1'b1;
			end
			`ALUOP_SLL, `ALUOP_SRL, `ALUOP_SRA: begin
				ctl.wr_en  = 1'b1;
				ctl.rt_ren = 1'b1; // amount comes from shamt.
			end
			`ALUOP_ANDI, `ALUOP_ORI, `ALUOP_XORI, `ALUOP_ADDI,
			`ALUOP_ADDIU, `ALUOP_SLTI, `ALUOP_SLTIU: begin
				ctl.wr_en   = 1'b1;
				ctl.wr_addr = rt;
				ctl.rs_ren  = 1'b1;
			end
			`ALUOP_LUI: begin
				ctl.wr_en   = 1'b1;
				ctl.wr_addr = rt;
			end
			`ALUOP_LB, `ALUOP_LBU, `ALUOP_LH, `ALUOP_LHU, `ALUOP_LW: begin
				ctl.wr_en      = 1'b1;
				ctl.wr_addr    = rt;
				ctl.rs_ren     = 1'b1;
				ctl.mem_to_reg = 1'b1;
			end
			`ALUOP_SB, `ALUOP_SH, `ALUOP_SW: begin
				ctl.ram_we = 1'b1;
				ctl.rs_ren = 1'b1;
				ctl.rt_ren = 1'b1;
			end
			`ALUOP_BEQ, `ALUOP_BNE: begin
				ctl.rs_ren = 1'b1;
				ctl.rt_ren = 1'b1;
			end
			`ALUOP_BGTZ, `ALUOP_BLEZ, `ALUOP_BGEZ, `ALUOP_BLTZ, `ALUOP_JR: begin
				ctl.rs_ren = 1'b1;
			end
			`ALUOP_BGEZAL, `ALUOP_BLTZAL: begin
				ctl.rs_ren  = 1'b1;
				ctl.wr_en   = 1'b1;
				ctl.wr_addr = reg_idx_t'(31);
				ctl.link    = 1'b1;
			end
			`ALUOP_JAL: begin
				ctl.wr_en   = 1'b1;
				ctl.wr_addr = reg_idx_t'(31);
				ctl.link    = 1'b1;
			end
			`ALUOP_JALR: begin
				ctl.rs_ren = 1'b1;
				ctl.wr_en  = 1'b1; // rd as written.
				ctl.link   = 1'b1;
			end
			default: ;
		endcase
	end

	assign ctl.aluop       = aluop;
	assign ctl.instr_valid = (aluop != `ALUOP_NOP);

endmodule

/* operand_bypass.sv */
`timescale 1ns/1ps

module operand_bypass import id_pkg::*; (
	dec_if.sink      ctl,
	input  word_t    instr_i,
	input  word_t    rs_data_i,
	input  word_t    rt_data_i,
	input  logic     ex_wr_en_i,
	input  reg_idx_t ex_wr_addr_i,
	input  word_t    ex_wr_data_i,
	input  logic     mem_wr_en_i,
	input  reg_idx_t mem_wr_addr_i,
	input  word_t    mem_wr_data_i,
	input  logic     exe_mem_to_reg_i,
	input  reg_idx_t exe_wr_addr_i,
	output word_t    rs_val_o,
	output word_t    rt_val_o,
	output logic     hazard_o
);

	reg_idx_t rs;
	reg_idx_t rt;

	assign rs = instr_i[25:21];
	assign rt = instr_i[20:16];

	// execute stage first, then memory, then register file.
	function automatic word_t pick(input logic ren, input reg_idx_t idx, input word_t rf_val);
		if (!ren)
			return '0;
		if (ex_wr_en_i && ex_wr_addr_i == idx)
			return ex_wr_data_i;
		if (mem_wr_en_i && mem_wr_addr_i == idx)
			return mem_wr_data_i;
		return rf_val;
	endfunction

	always_comb begin
		rs_val_o = pick(ctl.rs_ren, rs, rs_data_i);
		rt_val_o = pick(ctl.rt_ren, rt, rt_data_i);
	end

	// load data is not ready until after memory.
	assign hazard_o = exe_mem_to_reg_i &&
		((ctl.rs_ren && exe_wr_addr_i == rs) || (ctl.rt_ren && exe_wr_addr_i == rt));

endmodule

/* tb.f */
+incdir+.
id_pkg.sv
id_dec_if.sv
instr_decoder.sv
operand_bypass.sv
branch_unit.sv
id_ex_reg.sv
id_top.sv
id_sva.sv
tb_checker.sv
tb_top.sv

/* tb_checker.sv */
`timescale 1ns/1ps

module tb_checker import id_pkg::*; (
	input logic     clk,
	input logic     rst,
	input logic     out_valid_o,
	input logic     out_ready_i,
	input word_t    pc_o,
	input word_t    instr_o,
	input aluop_t   aluop_o,
	input word_t    rs_data_o,
	input word_t    rt_data_o,
	input imm16_t   imm16_o,
	input logic     wr_en_o,
	input reg_idx_t wr_addr_o,
	input logic     mem_to_reg_o,
	input logic     ram_we_o,
	input word_t    return_addr_o,
	input logic     branch_en_o,
	input word_t    branch_addr_o,
	input logic     instr_valid_o
);

	typedef struct packed {
		word_t    pc;
		word_t    instr;
		aluop_t   aluop;
		logic     wr_en;
		reg_idx_t wr_addr;
		logic     mem_to_reg;
		logic     ram_we;
		word_t    rs;
		word_t    rt;
		word_t    ret;
		logic     ben;
		word_t    baddr;
		logic     iv;
	} exp_t;

	exp_t  exp_q[$];
	string name_q[$];
	int    pass_cnt = 0;
	int    fail_cnt = 0;
	int    err_cnt  = 0;

	task automatic push_expect(input string name, input word_t pc, input word_t instr,
		input aluop_t aluop, input logic wr_en, input reg_idx_t wr_addr,
		input logic mem_to_reg, input logic ram_we, input word_t rs, input word_t rt,
		input word_t ret, input logic ben, input word_t baddr, input logic iv);
		exp_t e;
		e = '{pc, instr, aluop, wr_en, wr_addr, mem_to_reg, ram_we, rs, rt, ret, ben, baddr, iv};
		exp_q.push_back(e);
		name_q.push_back(name);
	endtask

	task automatic note_error(input string msg);
		$display("%s", msg);
		err_cnt++;
	endtask

	task automatic compare(input string sig, input logic [31:0] got, input logic [31:0] exp,
		inout logic bad);
		if (got !== exp) begin
			$display("Mismatch %s: got %h expected %h", sig, got, exp);
			bad = 1'b1;
		end
	endtask

	// ============================================================
	// compare on each output handshake
	// ============================================================
	always @(posedge clk) begin
		exp_t  e;
		string name;
		logic  bad;
		if (rst && out_valid_o && out_ready_i) begin
			if (exp_q.size() == 0) begin
				note_error("an output appeared while no instruction was pending");
			end else begin
				e    = exp_q.pop_front();
				name = name_q.pop_front();
				bad  = 1'b0;
				compare("pc_o", pc_o, e.pc, bad);
				compare("instr_o", instr_o, e.instr, bad);
				compare("aluop_o", 32'(aluop_o), 32'(e.aluop), bad);
				compare("imm16_o", 32'(imm16_o), 32'(e.instr[15:0]), bad);
				compare("wr_en_o", 32'(wr_en_o), 32'(e.wr_en), bad);
				if (e.wr_en)
					compare("wr_addr_o", 32'(wr_addr_o), 32'(e.wr_addr), bad);
				compare("mem_to_reg_o", 32'(mem_to_reg_o), 32'(e.mem_to_reg), bad);
				compare("ram_we_o", 32'(ram_we_o), 32'(e.ram_we), bad);
				compare("rs_data_o", rs_data_o, e.rs, bad);
				compare("rt_data_o", rt_data_o, e.rt, bad);
				compare("return_addr_o", return_addr_o, e.ret, bad);
				compare("branch_en_o", 32'(branch_en_o), 32'(e.ben), bad);
				compare("branch_addr_o", branch_addr_o, e.baddr, bad);
				compare("instr_valid_o", 32'(instr_valid_o), 32'(e.iv), bad);
				if (bad) begin
					$display("test %s: failed", name);
					fail_cnt++;
				end else begin
					$display("test %s: ok", name);
					pass_cnt++;
				end
			end
		end
	end

endmodule

/* tb_top.sv */
`timescale 1ns/1ps
`include "id_defs.svh"

module tb_top import id_pkg::*; ();

	localparam int MAX_TESTS = 40;

	logic     clk;
	logic     rst;
	logic     in_valid_i;
	word_t    pc_i;
	word_t    instr_i;
	word_t    rs_data_i;
	word_t    rt_data_i;
	logic     out_ready_i;
	logic     ex_wr_en_i;
	reg_idx_t ex_wr_addr_i;
	word_t    ex_wr_data_i;
	logic     mem_wr_en_i;
	reg_idx_t mem_wr_addr_i;
	word_t    mem_wr_data_i;
	logic     exe_mem_to_reg_i;
	reg_idx_t exe_wr_addr_i;
	logic     in_ready_o;
	logic     out_valid_o;
	word_t    pc_o;
	word_t    instr_o;
	aluop_t   aluop_o;
	word_t    rs_data_o;
	word_t    rt_data_o;
	imm16_t   imm16_o;
	logic     wr_en_o;
	reg_idx_t wr_addr_o;
	logic     mem_to_reg_o;
	logic     ram_we_o;
	word_t    return_addr_o;
	logic     branch_en_o;
	word_t    branch_addr_o;
	logic     instr_valid_o;

	// stimulus table.
	string    t_name [MAX_TESTS];
	word_t    t_instr [MAX_TESTS];
	word_t    t_pc [MAX_TESTS];
	word_t    t_rs [MAX_TESTS];
	word_t    t_rt [MAX_TESTS];
	logic     t_ex_en [MAX_TESTS];
	reg_idx_t t_ex_addr [MAX_TESTS];
	word_t    t_ex_data [MAX_TESTS];
	logic     t_mem_en [MAX_TESTS];
	reg_idx_t t_mem_addr [MAX_TESTS];
	word_t    t_mem_data [MAX_TESTS];
	int       t_ld [MAX_TESTS];      // cycles with a load in execute.
	reg_idx_t t_ld_addr [MAX_TESTS];
	logic     t_stall [MAX_TESTS];   // load-use stall expected.
	int       t_hold [MAX_TESTS];    // cycles of out_ready low.
	// expected outputs.
	aluop_t   e_aluop [MAX_TESTS];
	logic     e_wr_en [MAX_TESTS];
	reg_idx_t e_wr_addr [MAX_TESTS];
	logic     e_m2r [MAX_TESTS];
	logic     e_ramwe [MAX_TESTS];
	word_t    e_rs [MAX_TESTS];
	word_t    e_rt [MAX_TESTS];
	word_t    e_ret [MAX_TESTS];
	logic     e_ben [MAX_TESTS];
	word_t    e_baddr [MAX_TESTS];
	logic     e_iv [MAX_TESTS];

	int n_tests = 0;
	int cycles = 0;
	int limit_cycles = MAX_TESTS * 8 + 16;

	id_top DUT (.*);

	tb_checker u_check (.*);

	always #10 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= limit_cycles) begin
			$display("run stopped by timeout after %0d cycles", cycles);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	// ============================================================
	// table building
	// ============================================================
	task automatic add_test(input string name, input word_t instr, input word_t pc,
		input word_t rs, input word_t rt);
		t_name[n_tests]  = name;
		t_instr[n_tests] = instr;
		t_pc[n_tests]    = pc;
		t_rs[n_tests]    = rs;
		t_rt[n_tests]    = rt;
		t_ex_en[n_tests]  = 1'b0;
		t_mem_en[n_tests] = 1'b0;
		t_ex_addr[n_tests]  = '0;
		t_mem_addr[n_tests] = '0;
		t_ex_data[n_tests]  = '0;
		t_mem_data[n_tests] = '0;
		t_ld[n_tests]      = 0;
		t_ld_addr[n_tests] = '0;
		t_stall[n_tests]   = 1'b0;
		t_hold[n_tests]    = 0;
		n_tests++;
	endtask

	// these act on the last added entry.
	task automatic bypass(input logic ex_en, input reg_idx_t ex_addr, input word_t ex_data,
		input logic mem_en, input reg_idx_t mem_addr, input word_t mem_data);
		t_ex_en[n_tests-1]    = ex_en;
		t_ex_addr[n_tests-1]  = ex_addr;
		t_ex_data[n_tests-1]  = ex_data;
		t_mem_en[n_tests-1]   = mem_en;
		t_mem_addr[n_tests-1] = mem_addr;
		t_mem_data[n_tests-1] = mem_data;
	endtask

	task automatic load_in_ex(input int ld, input reg_idx_t addr, input logic stall);
		t_ld[n_tests-1]      = ld;
		t_ld_addr[n_tests-1] = addr;
		t_stall[n_tests-1]   = stall;
	endtask

	task automatic expect_out(input aluop_t aluop, input logic wr_en, input reg_idx_t wr_addr,
		input logic m2r, input logic ramwe, input word_t rs, input word_t rt,
		input word_t ret, input logic ben, input word_t baddr, input logic iv);
		e_aluop[n_tests-1]   = aluop;
		e_wr_en[n_tests-1]   = wr_en;
		e_wr_addr[n_tests-1] = wr_addr;
		e_m2r[n_tests-1]     = m2r;
		e_ramwe[n_tests-1]   = ramwe;
		e_rs[n_tests-1]      = rs;
		e_rt[n_tests-1]      = rt;
		e_ret[n_tests-1]     = ret;
		e_ben[n_tests-1]     = ben;
		e_baddr[n_tests-1]   = baddr;
		e_iv[n_tests-1]      = iv;
	endtask

	task automatic build_table();
		add_test("add", 32'h00221820, 32'h100, 32'h11, 32'h22);
		expect_out(`ALUOP_ADD, 1, 3, 0, 0, 32'h11, 32'h22, 0, 0, 0, 1);
		add_test("sll", 32'h000428C0, 32'h104, 32'h55, 32'h80);
		expect_out(`ALUOP_SLL, 1, 5, 0, 0, 0, 32'h80, 0, 0, 0, 1);
		add_test("sra", 32'h00063883, 32'h108, 32'h1, 32'hF0000000);
		expect_out(`ALUOP_SRA, 1, 7, 0, 0, 0, 32'hF0000000, 0, 0, 0, 1);
		add_test("ori_held", 32'h35091234, 32'h10C, 32'hA, 32'hB);
		t_hold[n_tests-1] = 3;
		expect_out(`ALUOP_ORI, 1, 9, 0, 0, 32'hA, 0, 0, 0, 0, 1);
		add_test("lui_behind", 32'h3C0AABCD, 32'h110, 32'h1, 32'h2);
		expect_out(`ALUOP_LUI, 1, 10, 0, 0, 0, 0, 0, 0, 0, 1);
		add_test("and_fwd", 32'h00221824, 32'h114, 32'h1, 32'h2);
		bypass(1, 1, 32'hE1, 1, 2, 32'hD2);
		expect_out(`ALUOP_AND, 1, 3, 0, 0, 32'hE1, 32'hD2, 0, 0, 0, 1);
		add_test("xor_fwd_prio", 32'h00A53026, 32'h118, 32'h5, 32'h5);
		bypass(1, 5, 32'hE5, 1, 5, 32'hD5);
		expect_out(`ALUOP_XOR, 1, 6, 0, 0, 32'hE5, 32'hE5, 0, 0, 0, 1);
		add_test("beq_taken", 32'h10220010, 32'h200, 32'h5, 32'h5);
		expect_out(`ALUOP_BEQ, 0, 0, 0, 0, 32'h5, 32'h5, 0, 1, 32'h244, 1);
		add_test("beq_untaken", 32'h10220010, 32'h200, 32'h5, 32'h6);
		expect_out(`ALUOP_BEQ, 0, 0, 0, 0, 32'h5, 32'h6, 0, 0, 0, 1);
		add_test("bne_taken", 32'h1422FFFC, 32'h300, 32'h1, 32'h2);
		expect_out(`ALUOP_BNE, 0, 0, 0, 0, 32'h1, 32'h2, 0, 1, 32'h2F4, 1);
		add_test("bne_untaken", 32'h14220010, 32'h300, 32'h5, 32'h5);
		expect_out(`ALUOP_BNE, 0, 0, 0, 0, 32'h5, 32'h5, 0, 0, 0, 1);
		add_test("bgtz_taken", 32'h1C200008, 32'h400, 32'h7, 32'h9);
		expect_out(`ALUOP_BGTZ, 0, 0, 0, 0, 32'h7, 0, 0, 1, 32'h424, 1);
		add_test("bgtz_untaken", 32'h1C200008, 32'h400, 32'h0, 32'h9);
		expect_out(`ALUOP_BGTZ, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1);
		add_test("blez_taken", 32'h18200008, 32'h400, 32'h0, 32'h9);
		expect_out(`ALUOP_BLEZ, 0, 0, 0, 0, 0, 0, 0, 1, 32'h424, 1);
		add_test("blez_untaken", 32'h18200008, 32'h400, 32'h3, 32'h9);
		expect_out(`ALUOP_BLEZ, 0, 0, 0, 0, 32'h3, 0, 0, 0, 0, 1);
		add_test("bgez_taken", 32'h04210008, 32'h500, 32'h0, 32'h9);
		expect_out(`ALUOP_BGEZ, 0, 0, 0, 0, 0, 0, 0, 1, 32'h524, 1);
		add_test("bgez_untaken", 32'h04210008, 32'h500, 32'h80000000, 32'h9);
		expect_out(`ALUOP_BGEZ, 0, 0, 0, 0, 32'h80000000, 0, 0, 0, 0, 1);
		add_test("bltz_taken", 32'h04200008, 32'h500, 32'h80000000, 32'h9);
		expect_out(`ALUOP_BLTZ, 0, 0, 0, 0, 32'h80000000, 0, 0, 1, 32'h524, 1);
		add_test("bltz_untaken", 32'h04200008, 32'h500, 32'h1, 32'h9);
		expect_out(`ALUOP_BLTZ, 0, 0, 0, 0, 32'h1, 0, 0, 0, 0, 1);
		add_test("bgezal_taken", 32'h04310008, 32'h600, 32'h0, 32'h9);
		expect_out(`ALUOP_BGEZAL, 1, 31, 0, 0, 0, 0, 32'h608, 1, 32'h624, 1);
		add_test("bltzal_untaken", 32'h04300008, 32'h600, 32'h1, 32'h9);
		expect_out(`ALUOP_BLTZAL, 1, 31, 0, 0, 32'h1, 0, 32'h608, 0, 0, 1);
		add_test("j", 32'h08000040, 32'h10000700, 32'h1, 32'h2);
		expect_out(`ALUOP_J, 0, 0, 0, 0, 0, 0, 0, 1, 32'h10000100, 1);
		add_test("jal", 32'h0C000040, 32'h10000700, 32'h1, 32'h2);
		expect_out(`ALUOP_JAL, 1, 31, 0, 0, 0, 0, 32'h10000708, 1, 32'h10000100, 1);
		add_test("jr", 32'h00200008, 32'h700, 32'h4000, 32'h2);
		expect_out(`ALUOP_JR, 0, 0, 0, 0, 32'h4000, 0, 0, 1, 32'h4000, 1);
		add_test("jalr", 32'h0020F809, 32'h800, 32'h5000, 32'h2);
		expect_out(`ALUOP_JALR, 1, 31, 0, 0, 32'h5000, 0, 32'h808, 1, 32'h5000, 1);
		add_test("lw", 32'h8C230004, 32'h900, 32'h1000, 32'h2);
		expect_out(`ALUOP_LW, 1, 3, 1, 0, 32'h1000, 0, 0, 0, 0, 1);
		add_test("sw", 32'hAC230008, 32'h904, 32'h1000, 32'h77);
		expect_out(`ALUOP_SW, 0, 0, 0, 1, 32'h1000, 32'h77, 0, 0, 0, 1);
		add_test("add_load_use", 32'h00221820, 32'h908, 32'h11, 32'h22);
		load_in_ex(3, 2, 1);
		expect_out(`ALUOP_ADD, 1, 3, 0, 0, 32'h11, 32'h22, 0, 0, 0, 1);
		add_test("lb_no_stall", 32'h80250000, 32'h90C, 32'h1000, 32'h99);
		load_in_ex(2, 5, 0);
		expect_out(`ALUOP_LB, 1, 5, 1, 0, 32'h1000, 0, 0, 0, 0, 1);
		add_test("bad_opcode", 32'hFC000000, 32'hA00, 32'h1, 32'h2);
		expect_out(`ALUOP_NOP, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
		add_test("bad_shift", 32'h002428C0, 32'hA04, 32'h1, 32'h2);
		expect_out(`ALUOP_NOP, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
	endtask

	// ============================================================
	// driving loop
	// ============================================================
	initial begin
		int   stall_cnt;
		int   ld_left;
		logic accepted;
		clk = 1'b0;
		rst = 1'b0;
		in_valid_i = 1'b0;
		pc_i = '0;
		instr_i = '0;
		rs_data_i = '0;
		rt_data_i = '0;
		out_ready_i = 1'b1;
		ex_wr_en_i = 1'b0;
		ex_wr_addr_i = '0;
		ex_wr_data_i = '0;
		mem_wr_en_i = 1'b0;
		mem_wr_addr_i = '0;
		mem_wr_data_i = '0;
		exe_mem_to_reg_i = 1'b0;
		exe_wr_addr_i = '0;
		stall_cnt = 0;
		build_table();
		limit_cycles = n_tests * 8 + 16;
		repeat (16) @(negedge clk);
		rst = 1'b1;
		for (int i = 0; i < n_tests; i++) begin
			in_valid_i    = 1'b1;
			pc_i          = t_pc[i];
			instr_i       = t_instr[i];
			rs_data_i     = t_rs[i];
			rt_data_i     = t_rt[i];
			ex_wr_en_i    = t_ex_en[i];
			ex_wr_addr_i  = t_ex_addr[i];
			ex_wr_data_i  = t_ex_data[i];
			mem_wr_en_i   = t_mem_en[i];
			mem_wr_addr_i = t_mem_addr[i];
			mem_wr_data_i = t_mem_data[i];
			exe_wr_addr_i = t_ld_addr[i];
			ld_left       = t_ld[i];
			if (t_hold[i] > 0)
				stall_cnt = t_hold[i];
			accepted = 1'b0;
			while (!accepted) begin
				out_ready_i = (stall_cnt == 0);
				if (stall_cnt > 0)
					stall_cnt--;
				exe_mem_to_reg_i = (ld_left > 0);
				#1;
				if (ld_left > 0 && t_stall[i] && in_ready_o)
					u_check.note_error({"test ", t_name[i], ": accepted during a load-use stall"});
				if (ld_left > 0 && !t_stall[i] && out_ready_i && !in_ready_o)
					u_check.note_error({"test ", t_name[i], ": stalled with no load-use conflict"});
				if (ld_left > 0)
					ld_left--;
				accepted = in_ready_o;
				if (accepted)
					u_check.push_expect(t_name[i], t_pc[i], t_instr[i], e_aluop[i], e_wr_en[i],
						e_wr_addr[i], e_m2r[i], e_ramwe[i], e_rs[i], e_rt[i], e_ret[i],
						e_ben[i], e_baddr[i], e_iv[i]);
				@(negedge clk);
			end
		end
		in_valid_i       = 1'b0;
		exe_mem_to_reg_i = 1'b0;
		out_ready_i      = 1'b1;
		while (u_check.pass_cnt + u_check.fail_cnt < n_tests)
			@(negedge clk);
		repeat (3) @(negedge clk); // catch any extra output.
		$display("tests %0d, passed %0d, failed %0d, other errors %0d, assertion failures %0d",
			n_tests, u_check.pass_cnt, u_check.fail_cnt, u_check.err_cnt,
			DUT.u_id_ex_reg.u_sva.err_cnt);
		if (u_check.fail_cnt == 0 && u_check.err_cnt == 0 && u_check.pass_cnt == n_tests &&
			DUT.u_id_ex_reg.u_sva.err_cnt == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule
